/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = umi_flex_tb
FILELIST = umi_flex.f
OBJDIR   = obj_dir

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJDIR)

/* dv/umi_flex_ref.svh */
//####################
// Split reference model
//####################
`ifndef UMI_FLEX_REF_SVH
`define UMI_FLEX_REF_SVH

// One expected output beat
typedef struct packed {
   umi_pkg::umi_hdr_t hdr;
   logic [ODW-1:0]    data;
} chunk_t;

chunk_t exp_q[$];   // Expected chunks, oldest first

// xorshift32 step
function automatic logic [31:0] next_rand(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

// Cut a packet into output beats and queue them
function automatic void push_expected(input umi_pkg::umi_hdr_t hdr,
                                      input logic [IDW-1:0]  data);
   umi_pkg::umi_hdr_t         rest;
   logic [IDW-1:0]            rest_data;
   umi_flex_pkg::chunk_info_t info;
   chunk_t                    c;
   int                        bytes;
   int                        elems;
   rest           = hdr;
   rest_data      = data;
   info.remaining = {1'b0, hdr.cmd.len} + 9'd1;
   info.first     = 1'b1;
   while (1)
   begin
      bytes = ODW / 8;
      if (SPLIT == 1 && info.first)
         bytes = ODW / 8 - int'(rest.dstaddr % (ODW / 8));   // Up to beat edge
      elems  = bytes >> rest.cmd.size;
      c.hdr  = rest;
      c.data = rest_data[ODW-1:0];
      if (int'(info.remaining) <= elems)
      begin
         exp_q.push_back(c);   // Last chunk keeps eom
         break;
      end
      c.hdr.cmd.len  = 8'(elems - 1);
      c.hdr.cmd.eom  = 1'b0;
      exp_q.push_back(c);
      info.remaining = info.remaining - 9'(elems);
      info.first     = 1'b0;
      rest.cmd.len   = 8'(int'(info.remaining) - 1);
      rest.dstaddr   = rest.dstaddr + 64'(bytes);
      rest.srcaddr   = rest.srcaddr + 64'(bytes);
      rest_data      = rest_data >> (bytes * 8);
   end
endfunction

`endif

/* dv/umi_flex_tb.sv */
//####################
// UMI flex testbench
//####################
module umi_flex_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int IDW        = umi_flex_pkg::IDW_DEF;
   localparam int ODW        = umi_flex_pkg::ODW_DEF;
   localparam int DEPTH      = umi_flex_pkg::DEPTH_DEF;
   localparam int SPLIT      = umi_flex_pkg::SPLIT_DEF;
   localparam int CLK_PERIOD = 40;
   localparam int N_FIT      = 6;    // Packets per test
   localparam int N_DIRECT   = 4;
   localparam int N_SPLIT    = 10;
   localparam int N_RAND     = 16;
   localparam int MAX_CHUNKS = IDW / ODW;
   localparam int TOTAL_PKTS = N_FIT + N_DIRECT + N_SPLIT + 3 * N_RAND + DEPTH / 2;
   localparam int WD_CYCLES  = TOTAL_PKTS * MAX_CHUNKS * 10 + 200;   // With margin

`include "umi_flex_ref.svh"

   logic              umi_in_clk;
   logic              umi_in_nreset;
   logic              bypass;
   logic              chaosmode;
   logic              fifo_full;
   logic              fifo_empty;
   logic              umi_in_valid;
   umi_pkg::umi_hdr_t umi_in_hdr;
   logic [IDW-1:0]    umi_in_data;
   logic              umi_in_ready;
   logic              umi_out_valid;
   umi_pkg::umi_hdr_t umi_out_hdr;
   logic [ODW-1:0]    umi_out_data;
   logic              umi_out_ready;

   int                errors;
   int                beats;
   string             test_name;
   logic [31:0]       stim_state;
   logic [31:0]       ready_state;
   logic [31:0]       saved_state;
   int                ready_mode;   // 0 always, 1 random, 2 held low
   int                mode_now;
   chunk_t            exp_chunk;
   umi_pkg::umi_hdr_t pkt_hdr;
   logic [IDW-1:0]    pkt_data;

   umi_flex UUT (.*);

   always #(CLK_PERIOD / 2) umi_in_clk = ~umi_in_clk;

   //####################
   // Helpers
   //####################

   function automatic logic [31:0] stim_rand();
      stim_state = next_rand(stim_state);
      return stim_state;
   endfunction

   task automatic tick();
      @(posedge umi_in_clk);
      #2;
   endtask

   task automatic report_mismatch(input string field, input logic [159:0] exp_val,
                                  input logic [159:0] act_val);
      errors++;
      $display("** Error %s %s: expected %h actual %h", test_name, field, exp_val, act_val);
   endtask

   task automatic random_packet(input bit fit_only, output umi_pkg::umi_hdr_t hdr,
                                output logic [IDW-1:0] data);
      logic [31:0] r;
      int          max_elems;
      hdr.cmd.opcode = 5'(stim_rand());
      hdr.cmd.size   = 3'(stim_rand() % 32'd4);   // Elements no wider than ODW
      max_elems      = (fit_only ? ODW / 8 : IDW / 8) >> hdr.cmd.size;
      hdr.cmd.len    = 8'(stim_rand() % 32'(max_elems));
      r              = stim_rand();
      hdr.cmd.atype  = r[7:0];
      hdr.cmd.qos    = r[11:8];
      hdr.cmd.prot   = r[13:12];
      hdr.cmd.eom    = r[14];
      hdr.cmd.eof    = r[15];
      hdr.dstaddr    = {stim_rand(), stim_rand()};
      hdr.srcaddr    = {stim_rand(), stim_rand()};
      for (int i = 0; i < IDW / 32; i++)
         data[i*32 +: 32] = stim_rand();
   endtask

   // Called 2 ns after an edge, returns 2 ns after the accepting edge
   task automatic send_packet(input umi_pkg::umi_hdr_t hdr, input logic [IDW-1:0] data);
      bit taken;
      int waited;
      taken        = 1'b0;
      waited       = 0;
      umi_in_valid = 1'b1;
      umi_in_hdr   = hdr;
      umi_in_data  = data;
      push_expected(hdr, data);
      while (!taken && waited < 200)
      begin
         @(negedge umi_in_clk);
         taken = umi_in_ready;
         tick();
         waited++;
      end
      if (!taken)
      begin
         errors++;
         $display("Test %s: input packet was never accepted", test_name);
      end
      umi_in_valid = 1'b0;
   endtask

   task automatic run_random(input int count);
      for (int i = 0; i < count; i++)
      begin
         random_packet(1'b0, pkt_hdr, pkt_data);
         send_packet(pkt_hdr, pkt_data);
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 400)
      begin
         tick();
         n++;
      end
      if (exp_q.size() != 0)
      begin
         errors++;
         $display("Test %s: %0d chunks never came out", test_name, exp_q.size());
         exp_q.delete();
      end
      tick();
   endtask

   //####################
   // Output side
   //####################

   always @(posedge umi_in_clk)
   begin
      mode_now    = ready_mode;
      ready_state = next_rand(ready_state);
      #2;
      umi_out_ready = (mode_now == 0) | ((mode_now == 1) & ready_state[3]);
   end

   // Beat seen at mid cycle transfers on the next edge
   always @(negedge umi_in_clk)
   begin
      if (umi_in_nreset && umi_out_valid && umi_out_ready)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("Test %s: output beat arrived with nothing expected", test_name);
         end
         else
         begin
            exp_chunk = exp_q.pop_front();
            beats++;
            if (umi_out_hdr !== exp_chunk.hdr)
               report_mismatch("hdr", exp_chunk.hdr, umi_out_hdr);
            if (umi_out_data !== exp_chunk.data)
               report_mismatch("data", exp_chunk.data, umi_out_data);
         end
      end
   end

   initial
   begin
      #(WD_CYCLES * CLK_PERIOD);
      $display("Watchdog expired, the run did not finish in time");
      $display("RESULT: FAIL");
      $finish;
   end

   //####################
   // Main sequence
   //####################

   initial
   begin
      umi_in_clk    = 1'b0;
      umi_in_nreset = 1'b0;
      bypass        = 1'b0;
      chaosmode     = 1'b0;
      umi_in_valid  = 1'b0;
      umi_in_hdr    = '0;
      umi_in_data   = '0;
      umi_out_ready = 1'b1;
      ready_mode    = 0;
      errors        = 0;
      beats         = 0;
      stim_state    = 32'd39964;
      ready_state   = next_rand(32'd39964);
      test_name     = "reset";
      repeat (3) @(posedge umi_in_clk);
      #2;
      if (fifo_empty !== 1'b1)
         report_mismatch("fifo_empty", 1, fifo_empty);
      if (fifo_full !== 1'b0)
         report_mismatch("fifo_full", 0, fifo_full);
      if (umi_out_valid !== 1'b0)
         report_mismatch("out_valid", 0, umi_out_valid);
      umi_in_nreset = 1'b1;
      if (umi_in_ready !== 1'b0)
         report_mismatch("in_ready", 0, umi_in_ready);
      tick();
      if (umi_in_ready !== 1'b0)
         report_mismatch("in_ready hold", 0, umi_in_ready);
      tick();
      if (umi_in_ready !== 1'b1)
         report_mismatch("in_ready open", 1, umi_in_ready);

      test_name = "fit";
      for (int i = 0; i < N_FIT; i++)
      begin
         random_packet(1'b1, pkt_hdr, pkt_data);
         send_packet(pkt_hdr, pkt_data);
      end
      wait_drain();

      // Largest splits first, one per element size
      test_name = "split";
      for (int i = 0; i < N_DIRECT; i++)
      begin
         random_packet(1'b0, pkt_hdr, pkt_data);
         pkt_hdr.cmd.size = 3'(3 - i);
         pkt_hdr.cmd.len  = 8'(((IDW / 8) >> (3 - i)) - 1);
         send_packet(pkt_hdr, pkt_data);
      end
      run_random(N_SPLIT);
      wait_drain();

      test_name   = "backpressure";
      ready_mode  = 1;
      saved_state = stim_state;
      run_random(N_RAND);
      wait_drain();

      test_name  = "fifo_full";
      ready_mode = 2;
      tick();
      for (int i = 0; i < DEPTH / 2; i++)
      begin
         random_packet(1'b0, pkt_hdr, pkt_data);
         pkt_hdr.cmd.size = 3'd3;
         pkt_hdr.cmd.len  = 8'd1;    // Two chunks each
         send_packet(pkt_hdr, pkt_data);
      end
      if (fifo_full !== 1'b0)
         report_mismatch("fifo_full early", 0, fifo_full);
      for (int n = 0; n < 8 && fifo_full !== 1'b1; n++)
         tick();
      if (fifo_full !== 1'b1)
      begin
         errors++;
         $display("Test %s: fifo_full did not rise with the FIFO filled", test_name);
      end
      if (fifo_empty !== 1'b0)
         report_mismatch("fifo_empty filled", 0, fifo_empty);
      ready_mode = 1;
      wait_drain();

      test_name  = "bypass";
      bypass     = 1'b1;
      stim_state = saved_state;   // Replay the backpressure packets
      run_random(N_RAND);
      wait_drain();

      test_name  = "chaos";
      bypass     = 1'b0;
      chaosmode  = 1'b1;
      stim_state = saved_state;
      run_random(N_RAND);
      wait_drain();

      $display("Checked %0d output beats, %0d errors", beats, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* logic/umi_flex.sv */
//####################
// UMI width converter
//####################
module umi_flex
  #(parameter int IDW   = umi_flex_pkg::IDW_DEF,
    parameter int ODW   = umi_flex_pkg::ODW_DEF,
    parameter int DEPTH = umi_flex_pkg::DEPTH_DEF,
    parameter int SPLIT = umi_flex_pkg::SPLIT_DEF)
   (
   input  logic              umi_in_clk,
   input  logic              umi_in_nreset,
   input  logic              bypass,         // Skip the FIFO
   input  logic              chaosmode,      // Random write hold-off
   output logic              fifo_full,
   output logic              fifo_empty,
   input  logic              umi_in_valid,
   input  umi_pkg::umi_hdr_t umi_in_hdr,
   input  logic [IDW-1:0]    umi_in_data,
   output logic              umi_in_ready,
   output logic              umi_out_valid,
   output umi_pkg::umi_hdr_t umi_out_hdr,
   output logic [ODW-1:0]    umi_out_data,
   input  logic              umi_out_ready
   );

   // Input slice to splitter
   logic              stage_valid;
   umi_pkg::umi_hdr_t stage_hdr;
   logic [IDW-1:0]    stage_data;
   logic              stage_ready;

   // Splitter to FIFO
   logic              chunk_valid;
   umi_pkg::umi_hdr_t chunk_hdr;
   logic [ODW-1:0]    chunk_data;
   logic              chunk_ready;

   umi_in_stage #(.IDW(IDW))
   in_stage_i (.umi_in_clk    (umi_in_clk),
               .umi_in_nreset (umi_in_nreset),
               .in_valid      (umi_in_valid),
               .in_hdr        (umi_in_hdr),
               .in_data       (umi_in_data),
               .in_ready      (umi_in_ready),
               .stage_valid   (stage_valid),
               .stage_hdr     (stage_hdr),
               .stage_data    (stage_data),
               .stage_ready   (stage_ready));

   umi_splitter #(.IDW(IDW), .ODW(ODW), .SPLIT(SPLIT))
   splitter_i (.umi_in_clk    (umi_in_clk),
               .umi_in_nreset (umi_in_nreset),
               .stage_valid   (stage_valid),
               .stage_hdr     (stage_hdr),
               .stage_data    (stage_data),
               .stage_ready   (stage_ready),
               .chunk_valid   (chunk_valid),
               .chunk_hdr     (chunk_hdr),
               .chunk_data    (chunk_data),
               .chunk_ready   (chunk_ready));

   umi_sync_fifo #(.ODW(ODW), .DEPTH(DEPTH))
   fifo_i (.umi_in_clk    (umi_in_clk),
           .umi_in_nreset (umi_in_nreset),
           .bypass        (bypass),
           .chaosmode     (chaosmode),
           .wr_valid      (chunk_valid),
           .wr_hdr        (chunk_hdr),
           .wr_data       (chunk_data),
           .wr_ready      (chunk_ready),
           .out_valid     (umi_out_valid),
           .out_hdr       (umi_out_hdr),
           .out_data      (umi_out_data),
           .out_ready     (umi_out_ready),
           .fifo_full     (fifo_full),
           .fifo_empty    (fifo_empty));

endmodule

/* logic/umi_flex_pkg.sv */
//####################
// Flex buffer config
//####################
package umi_flex_pkg;

   // Top level defaults
   localparam int IDW_DEF   = 256;   // Input data width
   localparam int ODW_DEF   = 64;    // Output data width
   localparam int DEPTH_DEF = 4;     // Chunk FIFO entries
   localparam int SPLIT_DEF = 0;     // Split on beat boundary when 1

   //####################
   // Split bookkeeping
   //####################

   // Progress of the packet being split
   typedef struct packed {
      logic [8:0] remaining;   // Elements not yet sent
      logic       first;       // Nothing of this packet sent yet
   } chunk_info_t;

endpackage

/* logic/umi_in_stage.sv */
//####################
// UMI input slice
//####################
module umi_in_stage
  #(parameter int IDW = 256)
   (
   input  logic              umi_in_clk,
   input  logic              umi_in_nreset,
   input  logic              in_valid,
   input  umi_pkg::umi_hdr_t in_hdr,
   input  logic [IDW-1:0]    in_data,
   output logic              in_ready,
   output logic              stage_valid,
   output umi_pkg::umi_hdr_t stage_hdr,
   output logic [IDW-1:0]    stage_data,
   input  logic              stage_ready
   );

   logic [1:0] start_sr;     // Start-up hold after reset
   logic       in_beat;

   // Ones shift in, ready opens after two edges
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         start_sr <= 2'b00;
      else
         start_sr <= {start_sr[0], 1'b1};
   end

   // Take a beat when empty or emptying now
   assign in_ready = start_sr[1] & (~stage_valid | stage_ready);
   assign in_beat  = in_valid & in_ready;

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         stage_valid <= 1'b0;
      else if (in_ready)
         stage_valid <= in_valid;
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (in_beat)
      begin
         stage_hdr  <= in_hdr;
         stage_data <= in_data;
      end
   end

   // Upstream keeps its beat steady until taken
   a_in_hold: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      in_valid && !in_ready |=>
         in_valid && $stable(in_hdr) && $stable(in_data));

endmodule

/* logic/umi_pkg.sv */
//####################
// UMI protocol types
//####################
package umi_pkg;

   localparam int CW = 32;   // Command width
   localparam int AW = 64;   // Address width

   //####################
   // Command word
   //####################

   // Declared MSB first, so opcode lands in bits 4:0
   typedef struct packed {
      logic       eof;       // End of frame
      logic       eom;       // End of message
      logic [1:0] prot;
      logic [3:0] qos;
      logic [7:0] atype;
      logic [7:0] len;       // Elements minus one
      logic [2:0] size;      // 2**size bytes per element
      logic [4:0] opcode;
   } umi_cmd_t;

   //####################
   // Packet header
   //####################

   // Command in the low bits, then destination, then source
   typedef struct packed {
      logic [AW-1:0] srcaddr;
      logic [AW-1:0] dstaddr;
      umi_cmd_t      cmd;
   } umi_hdr_t;

endpackage

/* logic/umi_splitter.sv */
//####################
// UMI packet splitter
//####################
module umi_splitter
  #(parameter int IDW   = 256,
    parameter int ODW   = 64,
    parameter int SPLIT = 0)
   (
   input  logic              umi_in_clk,
   input  logic              umi_in_nreset,
   input  logic              stage_valid,
   input  umi_pkg::umi_hdr_t stage_hdr,
   input  logic [IDW-1:0]    stage_data,
   output logic              stage_ready,
   output logic              chunk_valid,
   output umi_pkg::umi_hdr_t chunk_hdr,
   output logic [ODW-1:0]    chunk_data,
   input  logic              chunk_ready
   );

   localparam int OBW = ODW / 8;          // Bytes per output beat
   localparam int OAW = $clog2(OBW);      // Byte offset bits in a beat
   localparam int BCW = OAW + 1;          // Byte count width
   localparam logic [BCW-1:0] BEAT_BYTES = BCW'(OBW);

   // Remainder latch
   logic                      rem_valid;
   umi_pkg::umi_hdr_t         rem_hdr;
   logic [IDW-1:0]            rem_data;
   umi_flex_pkg::chunk_info_t rem_info;

   // Packet being worked on
   umi_pkg::umi_hdr_t         cur_hdr;
   logic [IDW-1:0]            cur_data;
   umi_flex_pkg::chunk_info_t cur_info;

   logic [BCW-1:0]            chunk_bytes;
   logic [8:0]                beat_elems;
   logic [8:0]                chunk_elems;
   logic                      split_needed;
   logic                      chunk_beat;

   // What is left after this chunk
   umi_pkg::umi_hdr_t         next_hdr;
   logic [IDW-1:0]            next_data;
   umi_flex_pkg::chunk_info_t next_info;

   //####################
   // Current packet
   //####################

   always_comb
   begin
      if (rem_valid)
      begin
         cur_hdr  = rem_hdr;
         cur_data = rem_data;
         cur_info = rem_info;
      end
      else
      begin
         cur_hdr            = stage_hdr;
         cur_data           = stage_data;
         cur_info.remaining = {1'b0, stage_hdr.cmd.len} + 9'd1;
         cur_info.first     = 1'b1;
      end
   end

   // Boundary mode trims the first chunk to the next beat edge
   assign chunk_bytes = (SPLIT == 1 && cur_info.first) ?
                        BEAT_BYTES - BCW'(cur_hdr.dstaddr[OAW-1:0]) :
                        BEAT_BYTES;

   assign beat_elems   = 9'(BEAT_BYTES >> cur_hdr.cmd.size);
   assign chunk_elems  = 9'(chunk_bytes >> cur_hdr.cmd.size);
   assign split_needed = cur_info.remaining > chunk_elems;

   //####################
   // Chunk output
   //####################

   always_comb
   begin
      chunk_hdr = cur_hdr;
      if (split_needed)
      begin
         chunk_hdr.cmd.len = 8'(chunk_elems - 9'd1);
         chunk_hdr.cmd.eom = 1'b0;   // Only the last chunk ends the message
      end
   end

   assign chunk_data  = cur_data[ODW-1:0];
   assign chunk_valid = stage_valid;                    // Stage holds packet till done
   assign stage_ready = chunk_ready & ~split_needed;    // Release on last chunk
   assign chunk_beat  = chunk_valid & chunk_ready;

   //####################
   // Remainder
   //####################

   always_comb
   begin
      next_hdr            = cur_hdr;
      next_hdr.cmd.len    = cur_hdr.cmd.len - 8'(chunk_elems);
      next_hdr.dstaddr    = cur_hdr.dstaddr + {{(umi_pkg::AW-BCW){1'b0}}, chunk_bytes};
      next_hdr.srcaddr    = cur_hdr.srcaddr + {{(umi_pkg::AW-BCW){1'b0}}, chunk_bytes};
      next_data           = cur_data >> {chunk_bytes, 3'b000};
      next_info.remaining = cur_info.remaining - chunk_elems;
      next_info.first     = 1'b0;
   end

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         rem_valid <= 1'b0;
      else if (chunk_beat)
         rem_valid <= split_needed;
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (chunk_beat & split_needed)
      begin
         rem_hdr  <= next_hdr;
         rem_data <= next_data;
         rem_info <= next_info;
      end
   end

   //####################
   // Checks
   //####################

   // No chunk wider than one output beat
   a_len_fits: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      chunk_valid |-> ({1'b0, chunk_hdr.cmd.len} < beat_elems));

   // Remainder count never wraps and agrees with its len field
   a_rem_count: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      rem_valid |-> (rem_info.remaining != 9'd0) &&
                    (rem_info.remaining == {1'b0, rem_hdr.cmd.len} + 9'd1));

   // Upstream keeps the packet while chunks are pending
   a_rem_held: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      rem_valid |-> stage_valid);

endmodule

/* logic/umi_sync_fifo.sv */
//####################
// UMI chunk FIFO
//####################
module umi_sync_fifo
  #(parameter int ODW   = 64,
    parameter int DEPTH = 4)
   (
   input  logic              umi_in_clk,
   input  logic              umi_in_nreset,
   input  logic              bypass,
   input  logic              chaosmode,
   input  logic              wr_valid,
   input  umi_pkg::umi_hdr_t wr_hdr,
   input  logic [ODW-1:0]    wr_data,
   output logic              wr_ready,
   output logic              out_valid,
   output umi_pkg::umi_hdr_t out_hdr,
   output logic [ODW-1:0]    out_data,
   input  logic              out_ready,
   output logic              fifo_full,
   output logic              fifo_empty
   );

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   typedef struct packed {
      umi_pkg::umi_hdr_t hdr;
      logic [ODW-1:0]    data;
   } entry_t;

   entry_t        mem [DEPTH];
   entry_t        rd_entry;
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [PW:0]   count;
   logic [15:0]   lfsr;
   logic          chaos_hold;
   logic          raw_full;
   logic          raw_empty;
   logic          wr_en;
   logic          rd_en;

   //####################
   // Chaos generator
   //####################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         lfsr <= 16'hace1;
      else
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
   end

   assign chaos_hold = chaosmode & (lfsr[1:0] == 2'b00);   // About one in four

   //####################
   // Buffer
   //####################

   assign raw_full  = count == (PW+1)'(DEPTH);
   assign raw_empty = count == '0;

   assign wr_ready = bypass ? out_ready : ~raw_full & ~chaos_hold;
   assign wr_en    = ~bypass & wr_valid & wr_ready;
   assign rd_en    = ~bypass & ~raw_empty & out_ready;

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= (wr_ptr == PW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= (rd_ptr == PW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         if (wr_en & ~rd_en)
            count <= count + 1'b1;
         else if (rd_en & ~wr_en)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (wr_en)
         mem[wr_ptr] <= '{hdr: wr_hdr, data: wr_data};
   end

   assign rd_entry = mem[rd_ptr];

   //####################
   // Output and bypass
   //####################

   assign out_valid  = bypass ? wr_valid : ~raw_empty;
   assign out_hdr    = bypass ? wr_hdr   : rd_entry.hdr;
   assign out_data   = bypass ? wr_data  : rd_entry.data;
   assign fifo_full  = bypass ? ~out_ready : raw_full;
   assign fifo_empty = bypass | raw_empty;

   // Full stays full until a read, so no write slipped in
   a_no_overflow: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      !bypass && raw_full && !rd_en |=> raw_full && (wr_ptr == rd_ptr));

   // Empty stays empty until a write, so no read slipped out
   a_no_underflow: assert property (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      !bypass && raw_empty && !wr_en |=> raw_empty && (wr_ptr == rd_ptr));

endmodule

/* umi_flex.f */
+incdir+dv
logic/umi_pkg.sv
logic/umi_flex_pkg.sv
logic/umi_in_stage.sv
logic/umi_splitter.sv
logic/umi_sync_fifo.sv
logic/umi_flex.sv
dv/umi_flex_tb.sv
